//--- include/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// fetch pc after reset
`define FETCH_PC_INIT 32'h8000_0000

// l1i geometry: 4 lines of 2 words
`define L1I_IDX_W 2
`define L1I_WORDS 2

// one request, two beats inside this window
`define FETCH_BURST_LO 32'ha000_0000
`define FETCH_BURST_HI 32'hc000_0000

// rv32i major opcodes
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_SYSTEM 7'b1110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011

// fence.i, full encoding
`define INST_FENCE_I 32'h0000_100f

`endif

//--- verilog/fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

  // l1i refill sequence
  typedef enum logic [2:0] {
    IDLE,
    WORD0,
    GAP,
    WORD1,
    DONE
  } refill_state_e;

  // what the fetch stage does after handing out a word
  typedef enum logic [1:0] {
    PLAIN,
    FLOW,
    MEM,
    FENCE
  } inst_class_e;

  // address split: tag | index | word offset | byte offset
  localparam int IDX_W = `L1I_IDX_W;
  localparam int OFF_W = $clog2(`L1I_WORDS);
  localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

endpackage

`default_nettype wire

//--- verilog/icache_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface icache_port_if ();

  // fetch side
  logic [31:0] addr;
  logic        flush;

  // cache side
  logic [31:0]               inst;
  logic                      hit;
  fetch_pkg::refill_state_e  state;
  logic                      refill_idle;

  // no refill running, pc may move
  assign refill_idle = (state == fetch_pkg::IDLE);

  modport ctrl (
    output addr,
    output flush,
    input  inst,
    input  hit,
    input  refill_idle
  );

  modport cache (
    input  addr,
    input  flush,
    output inst,
    output hit,
    output state
  );

endinterface

`default_nettype wire

//--- verilog/l1i_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module l1i_cache (
  input  wire         clk,
  input  wire         rst,

  icache_port_if.cache port,

  // read port
  output logic [31:0] araddr_o,
  output logic        arvalid_o,
  output logic        required_o,
  input  wire  [31:0] rdata_i,
  input  wire         rvalid_i
);

  localparam int LINES   = 1 << `L1I_IDX_W;
  localparam int IDX_LSB = fetch_pkg::OFF_W + 2;
  localparam int TAG_LSB = IDX_LSB + fetch_pkg::IDX_W;

  logic [31:0]                 data_q [LINES][`L1I_WORDS];
  logic [fetch_pkg::TAG_W-1:0] tag_q  [LINES][`L1I_WORDS];
  logic [LINES-1:0]            line_valid_q;
  fetch_pkg::refill_state_e    state_q;

  logic [fetch_pkg::TAG_W-1:0] addr_tag;
  logic [fetch_pkg::IDX_W-1:0] addr_idx;
  logic [fetch_pkg::OFF_W-1:0] addr_off;
  logic [31:0]                 word0_addr;
  logic [31:0]                 word1_addr;
  logic                        burst;
  logic                        lookup;
  logic                        hit;

  assign addr_tag = port.addr[31:TAG_LSB];
  assign addr_idx = port.addr[TAG_LSB-1:IDX_LSB];
  assign addr_off = port.addr[IDX_LSB-1:2];

  // line base and last word of the line
  assign word0_addr = {port.addr[31:IDX_LSB], IDX_LSB'(0)};
  assign word1_addr = {port.addr[31:IDX_LSB], fetch_pkg::OFF_W'(`L1I_WORDS - 1), 2'b00};

  assign burst = (port.addr >= `FETCH_BURST_LO) && (port.addr <= `FETCH_BURST_HI);

  // array only readable outside a refill
  assign lookup = (state_q == fetch_pkg::IDLE) || (state_q == fetch_pkg::DONE);
  assign hit    = lookup && line_valid_q[addr_idx] && (tag_q[addr_idx][addr_off] == addr_tag);

  assign port.hit   = hit;
  assign port.inst  = data_q[addr_idx][addr_off];
  assign port.state = state_q;

  // one request per cycle of arvalid; split mode asks again from GAP
  always_comb begin
    arvalid_o = 1'b0;
    if (state_q == fetch_pkg::IDLE) begin
      arvalid_o = !hit;
    end else if (state_q == fetch_pkg::GAP) begin
      arvalid_o = !burst;
    end
  end

  assign araddr_o = ((state_q == fetch_pkg::IDLE) || (state_q == fetch_pkg::WORD0)) ?
                    word0_addr : word1_addr;

  assign required_o = (state_q != fetch_pkg::IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= fetch_pkg::IDLE;
      line_valid_q <= '0;
    end else begin
      case (state_q)
        fetch_pkg::IDLE: begin
          if (arvalid_o) begin
            state_q <= fetch_pkg::WORD0;
          end
        end
        fetch_pkg::WORD0: begin
          // burst keeps the second beat of the same request
          if (rvalid_i) begin
            state_q <= burst ? fetch_pkg::WORD1 : fetch_pkg::GAP;
          end
        end
        fetch_pkg::GAP: begin
          state_q <= fetch_pkg::WORD1;
        end
        fetch_pkg::WORD1: begin
          if (rvalid_i) begin
            line_valid_q[addr_idx] <= 1'b1;
            state_q                <= fetch_pkg::DONE;
          end
        end
        fetch_pkg::DONE: begin
          state_q <= fetch_pkg::IDLE;
        end
        default: begin
          state_q <= fetch_pkg::IDLE;
        end
      endcase
      // fence.i drops every line
      if (port.flush) begin
        line_valid_q <= '0;
      end
    end
  end

  // word and tag written as each beat lands
  always_ff @(posedge clk) begin
    if ((state_q == fetch_pkg::WORD0) && rvalid_i) begin
      data_q[addr_idx][0] <= rdata_i;
      tag_q[addr_idx][0]  <= addr_tag;
    end
    if ((state_q == fetch_pkg::WORD1) && rvalid_i) begin
      data_q[addr_idx][`L1I_WORDS-1] <= rdata_i;
      tag_q[addr_idx][`L1I_WORDS-1]  <= addr_tag;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_ctrl (
  input  wire         clk,
  input  wire         rst,

  icache_port_if.ctrl port,

  // back end resolution
  input  wire  [31:0] npc_i,
  input  wire  [31:0] pc_i,
  input  wire         pc_change_i,
  input  wire         pc_retire_i,
  input  wire         prev_valid_i,
  input  wire         next_ready_i,

  output logic [31:0] pc_o,
  output logic [31:0] inst_o,
  output logic        valid_o,
  output logic        ready_o,
  output logic        speculation_o,
  output logic        good_speculation_o,
  output logic        bad_speculation_o
);

  logic [31:0] pc_q;
  logic        hazard_q;

  // one-entry branch target register
  logic [31:0] btb_q;
  logic        btb_valid_q;

  // speculation tracking
  logic        spec_q;
  logic        spec_branch_q;
  logic [31:0] spec_target_q;
  logic [31:0] spec_fall_q;
  logic        good_q;
  logic        bad_q;
  logic [31:0] redirect_q;

  logic [6:0]             opcode;
  fetch_pkg::inst_class_e cls;
  logic                   resolve;
  logic                   mismatch;
  logic                   good_now;
  logic                   bad_now;
  logic                   handover;

  assign opcode = port.inst[6:0];

  always_comb begin
    if (port.inst == `INST_FENCE_I) begin
      cls = fetch_pkg::FENCE;
    end else if ((opcode == `OP_JAL) || (opcode == `OP_JALR) ||
                 (opcode == `OP_BRANCH) || (opcode == `OP_SYSTEM)) begin
      cls = fetch_pkg::FLOW;
    end else if ((opcode == `OP_LOAD) || (opcode == `OP_STORE)) begin
      cls = fetch_pkg::MEM;
    end else begin
      cls = fetch_pkg::PLAIN;
    end
  end

  // resolution checked against the stored target
  assign resolve  = prev_valid_i && (pc_change_i || pc_retire_i);
  assign mismatch = (pc_change_i && (npc_i != spec_target_q)) ||
                    (pc_retire_i && ((pc_i + 32'd4) != spec_target_q));
  assign good_now = spec_q && resolve && !mismatch;
  assign bad_now  = spec_q && resolve && mismatch;

  assign bad_speculation_o  = bad_q || bad_now;
  assign good_speculation_o = good_q;
  assign speculation_o      = spec_q;

  // no memory op leaves while on a speculated path
  assign valid_o = port.hit && !hazard_q && !bad_speculation_o &&
                   !(spec_q && (cls == fetch_pkg::MEM));
  assign ready_o = !valid_o;

  assign handover = valid_o && next_ready_i;

  assign port.addr  = pc_q;
  assign port.flush = handover && (cls == fetch_pkg::FENCE);

  assign pc_o   = pc_q;
  assign inst_o = port.inst;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q          <= `FETCH_PC_INIT;
      hazard_q      <= 1'b0;
      btb_valid_q   <= 1'b0;
      spec_q        <= 1'b0;
      spec_branch_q <= 1'b0;
      good_q        <= 1'b0;
      bad_q         <= 1'b0;
    end else begin
      good_q <= good_now;
      if (good_now) begin
        spec_q        <= 1'b0;
        spec_branch_q <= 1'b0;
      end
      if (bad_now) begin
        bad_q         <= 1'b1;
        spec_q        <= 1'b0;
        spec_branch_q <= 1'b0;
        // retired conditional branch falls through
        redirect_q    <= (spec_branch_q && !pc_change_i) ? spec_fall_q : npc_i;
      end

      // redirect once the cache is quiet
      if (bad_q && next_ready_i && port.refill_idle) begin
        bad_q    <= 1'b0;
        hazard_q <= 1'b0;
        pc_q     <= redirect_q;
      end

      // stall release
      if (hazard_q && !spec_q && resolve && port.refill_idle) begin
        hazard_q <= 1'b0;
        pc_q     <= pc_change_i ? npc_i : pc_q + 32'd4;
      end

      if (prev_valid_i && pc_change_i) begin
        btb_q       <= npc_i;
        btb_valid_q <= 1'b1;
      end

      if (handover) begin
        case (cls)
          fetch_pkg::PLAIN: begin
            pc_q <= pc_q + 32'd4;
          end
          fetch_pkg::FLOW: begin
            if (btb_valid_q && !spec_q) begin
              pc_q          <= btb_q;
              spec_q        <= 1'b1;
              spec_target_q <= btb_q;
              spec_fall_q   <= pc_q + 32'd4;
              spec_branch_q <= (opcode == `OP_BRANCH);
            end else begin
              hazard_q <= 1'b1;
            end
          end
          default: begin
            // loads, stores and fence.i wait for the back end
            hazard_q <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  wire         clk,
  input  wire         rst,

  // instruction read port
  output logic [31:0] araddr_o,
  output logic        arvalid_o,
  output logic        required_o,
  input  wire  [31:0] rdata_i,
  input  wire         rvalid_i,

  // pipeline side
  input  wire  [31:0] npc_i,
  input  wire  [31:0] pc_i,
  input  wire         pc_change_i,
  input  wire         pc_retire_i,
  input  wire         prev_valid_i,
  input  wire         next_ready_i,
  output logic [31:0] inst_o,
  output logic [31:0] pc_o,
  output logic        valid_o,
  output logic        ready_o,
  output logic        speculation_o,
  output logic        good_speculation_o,
  output logic        bad_speculation_o
);

  icache_port_if u_port ();

  fetch_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .port               (u_port.ctrl),
    .npc_i              (npc_i),
    .pc_i               (pc_i),
    .pc_change_i        (pc_change_i),
    .pc_retire_i        (pc_retire_i),
    .prev_valid_i       (prev_valid_i),
    .next_ready_i       (next_ready_i),
    .pc_o               (pc_o),
    .inst_o             (inst_o),
    .valid_o            (valid_o),
    .ready_o            (ready_o),
    .speculation_o      (speculation_o),
    .good_speculation_o (good_speculation_o),
    .bad_speculation_o  (bad_speculation_o)
  );

  l1i_cache u_cache (
    .clk        (clk),
    .rst        (rst),
    .port       (u_port.cache),
    .araddr_o   (araddr_o),
    .arvalid_o  (arvalid_o),
    .required_o (required_o),
    .rdata_i    (rdata_i),
    .rvalid_i   (rvalid_i)
  );

endmodule

`default_nettype wire

//--- test/fetch_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_chk (
  input wire        clk,
  input wire        rst,
  input wire        arvalid_i,
  input wire        valid_i,
  input wire        good_i,
  input wire        bad_i
);

  // a shown hit never goes to memory
  no_req_on_hit: assert property (@(posedge clk) disable iff (rst) valid_i |-> !arvalid_i)
    else $error("arvalid_o high while valid_o shows a hit");

  good_one_cycle: assert property (@(posedge clk) disable iff (rst) good_i |=> !good_i)
    else $error("good_speculation_o longer than one cycle");

  good_bad_apart: assert property (@(posedge clk) disable iff (rst) !(good_i && bad_i))
    else $error("good and bad speculation high together");

  // first cycle out of a reset edge
  quiet_in_reset: assert property (@(posedge clk) $past(rst) |-> !valid_i)
    else $error("valid_o high right after reset");

endmodule

bind fetch_top fetch_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .arvalid_i (arvalid_o),
  .valid_i   (valid_o),
  .good_i    (good_speculation_o),
  .bad_i     (bad_speculation_o)
);

`default_nettype wire

//--- test/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch;

  localparam logic [31:0] BASE = `FETCH_PC_INIT;
  localparam int N_STEPS = 26;
  localparam int CYCLE_LIMIT = N_STEPS * 40;

  localparam int RES_NONE   = 0;
  localparam int RES_CHANGE = 1;
  localparam int RES_RETIRE = 2;
  localparam int OUT_NONE = 0;
  localparam int OUT_GOOD = 1;
  localparam int OUT_BAD  = 2;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] rdata_i = 32'h0;
  logic        rvalid_i = 1'b0;
  logic [31:0] npc_i;
  logic [31:0] pc_i;
  logic        pc_change_i;
  logic        pc_retire_i;
  logic        prev_valid_i;
  logic        next_ready_i;
  logic [31:0] araddr_o;
  logic        arvalid_o;
  logic        required_o;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic        valid_o;
  logic        ready_o;
  logic        speculation_o;
  logic        good_speculation_o;
  logic        bad_speculation_o;

  // memory model state
  integer      seed;
  logic [31:0] rnd;
  logic        ready_pick = 1'b0;
  logic [31:0] mem_addr = 32'h0;
  logic [1:0]  beats_left = 2'd0;
  logic [1:0]  wait_cnt = 2'd0;
  int          req_count = 0;
  logic [31:0] first_req_addr = 32'h0;
  logic [31:0] last_req_addr = 32'h0;

  // step table
  logic [31:0] t_pc [N_STEPS];
  logic [31:0] t_inst [N_STEPS];
  int          t_res [N_STEPS];
  logic [31:0] t_npc [N_STEPS];
  logic        t_hold [N_STEPS];
  int          t_out [N_STEPS];
  int          t_reqs [N_STEPS];
  logic [31:0] t_last [N_STEPS];
  int          n_rows = 0;

  int err_cnt = 0;
  int pass_steps = 0;
  int fail_steps = 0;
  int cycle_cnt = 0;

  fetch_top dut0 (
    .clk                (clk),
    .rst                (rst),
    .araddr_o           (araddr_o),
    .arvalid_o          (arvalid_o),
    .required_o         (required_o),
    .rdata_i            (rdata_i),
    .rvalid_i           (rvalid_i),
    .npc_i              (npc_i),
    .pc_i               (pc_i),
    .pc_change_i        (pc_change_i),
    .pc_retire_i        (pc_retire_i),
    .prev_valid_i       (prev_valid_i),
    .next_ready_i       (next_ready_i),
    .inst_o             (inst_o),
    .pc_o               (pc_o),
    .valid_o            (valid_o),
    .ready_o            (ready_o),
    .speculation_o      (speculation_o),
    .good_speculation_o (good_speculation_o),
    .bad_speculation_o  (bad_speculation_o)
  );

  always #4 clk = ~clk;

  // program image with plain filler everywhere else
  function automatic logic [31:0] prog_word(input logic [31:0] addr);
    logic [31:0] w;
    case (addr)
      BASE + 32'h0c: w = {25'h01a2b3c, `OP_LOAD};
      BASE + 32'h14: w = {25'h00c4a5b, `OP_BRANCH};
      BASE + 32'h1c: w = {25'h0012345, `OP_JAL};
      BASE + 32'h24: w = `INST_FENCE_I;
      BASE + 32'h2c: w = {25'h0054321, `OP_JAL};
      BASE + 32'h34: w = {25'h0055aa1, `OP_LOAD};
      BASE + 32'h38: w = {25'h00abcde, `OP_JAL};
      default:       w = {addr[31:7] ^ addr[24:0], 7'b0010011};
    endcase
    return w;
  endfunction

  function automatic logic in_burst(input logic [31:0] addr);
    return (addr >= `FETCH_BURST_LO) && (addr <= `FETCH_BURST_HI);
  endfunction

  // memory responder with 1 to 4 cycles to the first beat
  always @(posedge clk) begin
    rnd = $random(seed);
    ready_pick <= rnd[8];
    if (rst) begin
      rvalid_i   <= 1'b0;
      beats_left <= 2'd0;
      req_count  <= 0;
    end else begin
      rvalid_i <= 1'b0;
      if (beats_left == 2'd0) begin
        if (arvalid_o) begin
          if (req_count == 0) begin
            first_req_addr <= araddr_o;
          end
          req_count     <= req_count + 1;
          last_req_addr <= araddr_o;
          mem_addr      <= araddr_o;
          beats_left    <= in_burst(araddr_o) ? 2'd2 : 2'd1;
          wait_cnt      <= rnd[1:0];
        end
      end else if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else begin
        rvalid_i   <= 1'b1;
        rdata_i    <= prog_word(mem_addr);
        mem_addr   <= mem_addr + 32'd4;
        beats_left <= beats_left - 2'd1;
      end
    end
  end

  // a beat on the bus means a refill is running
  always @(negedge clk) begin
    if (!rst && rvalid_i) begin
      compare_bit("required_o", required_o, 1'b1);
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycle_cnt = cycle_cnt + 1;
    end
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic add_step(input logic [31:0] pc, input int res, input logic [31:0] npc,
                          input logic hold, input int outcome, input int reqs,
                          input logic [31:0] last);
    t_pc[n_rows]   = pc;
    t_inst[n_rows] = prog_word(pc);
    t_res[n_rows]  = res;
    t_npc[n_rows]  = npc;
    t_hold[n_rows] = hold;
    t_out[n_rows]  = outcome;
    t_reqs[n_rows] = reqs;
    t_last[n_rows] = last;
    n_rows++;
  endtask

  task automatic build_table();
    add_step(BASE + 32'h00, RES_NONE, 32'h0, 1'b0, OUT_NONE, 2, BASE + 32'h04);
    add_step(BASE + 32'h04, RES_NONE, 32'h0, 1'b0, OUT_NONE, 2, BASE + 32'h04);
    add_step(BASE + 32'h08, RES_NONE, 32'h0, 1'b0, OUT_NONE, 4, BASE + 32'h0c);
    add_step(BASE + 32'h0c, RES_RETIRE, 32'h0, 1'b1, OUT_NONE, 4, BASE + 32'h0c);
    add_step(BASE + 32'h10, RES_NONE, 32'h0, 1'b0, OUT_NONE, 6, BASE + 32'h14);
    add_step(BASE + 32'h14, RES_CHANGE, BASE, 1'b1, OUT_NONE, 6, BASE + 32'h14);
    // second pass over cached lines
    add_step(BASE + 32'h00, RES_NONE, 32'h0, 1'b0, OUT_NONE, 6, BASE + 32'h14);
    add_step(BASE + 32'h04, RES_NONE, 32'h0, 1'b0, OUT_NONE, 6, BASE + 32'h14);
    add_step(BASE + 32'h08, RES_NONE, 32'h0, 1'b0, OUT_NONE, 6, BASE + 32'h14);
    add_step(BASE + 32'h0c, RES_RETIRE, 32'h0, 1'b1, OUT_NONE, 6, BASE + 32'h14);
    add_step(BASE + 32'h10, RES_NONE, 32'h0, 1'b0, OUT_NONE, 6, BASE + 32'h14);
    add_step(BASE + 32'h14, RES_RETIRE, 32'h0, 1'b0, OUT_BAD, 6, BASE + 32'h14);
    add_step(BASE + 32'h18, RES_NONE, 32'h0, 1'b0, OUT_NONE, 8, BASE + 32'h1c);
    add_step(BASE + 32'h1c, RES_CHANGE, BASE + 32'h34, 1'b0, OUT_BAD, 8, BASE + 32'h1c);
    add_step(BASE + 32'h34, RES_RETIRE, 32'h0, 1'b1, OUT_NONE, 10, BASE + 32'h34);
    // speculated target is a load and must be held back
    add_step(BASE + 32'h38, RES_CHANGE, BASE + 32'h20, 1'b1, OUT_BAD, 12, BASE + 32'h3c);
    add_step(BASE + 32'h20, RES_NONE, 32'h0, 1'b0, OUT_NONE, 14, BASE + 32'h24);
    add_step(BASE + 32'h24, RES_RETIRE, 32'h0, 1'b1, OUT_NONE, 14, BASE + 32'h24);
    add_step(BASE + 32'h28, RES_NONE, 32'h0, 1'b0, OUT_NONE, 18, BASE + 32'h2c);
    add_step(BASE + 32'h2c, RES_CHANGE, BASE + 32'h20, 1'b0, OUT_GOOD, 18, BASE + 32'h2c);
    add_step(BASE + 32'h20, RES_NONE, 32'h0, 1'b0, OUT_NONE, 18, BASE + 32'h2c);
    add_step(BASE + 32'h24, RES_CHANGE, `FETCH_BURST_LO, 1'b1, OUT_NONE, 18, BASE + 32'h2c);
    // burst window gives one request per line
    add_step(`FETCH_BURST_LO, RES_NONE, 32'h0, 1'b0, OUT_NONE, 21, `FETCH_BURST_LO);
    add_step(`FETCH_BURST_LO + 32'h4, RES_NONE, 32'h0, 1'b0, OUT_NONE, 21, `FETCH_BURST_LO);
    add_step(`FETCH_BURST_LO + 32'h8, RES_NONE, 32'h0, 1'b0, OUT_NONE, 22,
             `FETCH_BURST_LO + 32'h8);
    add_step(`FETCH_BURST_LO + 32'hc, RES_NONE, 32'h0, 1'b0, OUT_NONE, 22,
             `FETCH_BURST_LO + 32'h8);
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic run_step(input int i);
    int  errs_before;
    logic taken;
    errs_before = err_cnt;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      next_ready_i <= ready_pick;
      @(negedge clk);
      taken = valid_o && next_ready_i;
    end
    compare_word("pc_o", pc_o, t_pc[i]);
    compare_word("inst_o", inst_o, t_inst[i]);
    compare_bit("ready_o", ready_o, 1'b0);
    compare_count("request count", req_count, t_reqs[i]);
    compare_word("last araddr_o", last_req_addr, t_last[i]);
    if (i == 0) begin
      compare_word("first araddr_o", first_req_addr, BASE);
    end
    @(posedge clk);
    next_ready_i <= 1'b0;
    if (t_res[i] != RES_NONE) begin
      @(negedge clk);
      while (required_o || arvalid_o) begin
        @(negedge clk);
      end
      if (t_hold[i]) begin
        compare_bit("valid_o", valid_o, 1'b0);
        compare_bit("ready_o", ready_o, 1'b1);
      end
      compare_bit("speculation_o", speculation_o, t_out[i] != OUT_NONE);
      @(posedge clk);
      prev_valid_i <= 1'b1;
      pc_change_i  <= (t_res[i] == RES_CHANGE);
      pc_retire_i  <= (t_res[i] == RES_RETIRE);
      npc_i        <= t_npc[i];
      pc_i         <= t_pc[i];
      @(negedge clk);
      compare_bit("bad_speculation_o", bad_speculation_o, t_out[i] == OUT_BAD);
      compare_bit("good_speculation_o", good_speculation_o, 1'b0);
      @(posedge clk);
      prev_valid_i <= 1'b0;
      pc_change_i  <= 1'b0;
      pc_retire_i  <= 1'b0;
      @(negedge clk);
      compare_bit("good_speculation_o", good_speculation_o, t_out[i] == OUT_GOOD);
      compare_bit("bad_speculation_o", bad_speculation_o, t_out[i] == OUT_BAD);
      compare_bit("speculation_o", speculation_o, 1'b0);
      @(negedge clk);
      compare_bit("good_speculation_o", good_speculation_o, 1'b0);
    end
    if (err_cnt == errs_before) begin
      pass_steps++;
      $display("step %0d at pc %h: ok", i, t_pc[i]);
    end else begin
      fail_steps++;
      $display("step %0d at pc %h: failed", i, t_pc[i]);
    end
  endtask

  initial begin
    seed         = 23156;
    rst          = 1'b1;
    npc_i        = 32'h0;
    pc_i         = 32'h0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      run_step(i);
    end
    $display("steps %0d, passed %0d, failed %0d, errors %0d",
             n_rows, pass_steps, fail_steps, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
verilog/fetch_pkg.sv
verilog/icache_port_if.sv
verilog/l1i_cache.sv
verilog/fetch_ctrl.sv
verilog/fetch_top.sv
test/fetch_chk.sv
test/tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash
# build the fetch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch -f build.f -o tb_fetch \
  || { echo "build failed"; exit 1; }

./obj_dir/tb_fetch | tee /dev/stderr | grep "^PASS: all tests$" > /dev/null \
  && exit 0 \
  || exit 1
